/* build.f */
+incdir+logic
logic/snd_dma_pkg.sv
logic/bus_decode.sv
logic/snd_regs.sv
logic/snd_counter.sv
logic/snd_dma_top.sv
verification/tb_clock_gen.sv
verification/snd_dma_tb.sv

/* Bender.yml */
package:
  name: snd_dma

export_include_dirs:
  - logic

sources:
  - logic/snd_dma_pkg.sv
  - logic/bus_decode.sv
  - logic/snd_regs.sv
  - logic/snd_counter.sv
  - logic/snd_dma_top.sv
  - target: test
    files:
      - verification/tb_clock_gen.sv
      - verification/snd_dma_tb.sv

/* verification/snd_dma_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "snd_dma_cfg.svh"

module snd_dma_tb;
    import snd_dma_pkg::*;

    localparam int WAIT_MAX = 200;   // Cycles allowed for any single wait

    logic                 clk32;
    logic                 resb;
    logic                 as_n, rw, lds_n, sreq;
    logic [2:0]           fc;
    logic [23:1]          addr;
    logic [7:0]           din, dout;
    logic                 dtack_n, berr_n, dma_req, sint;
    logic [`SND_ADDR_W:1] dma_addr;

    // Reference model of registers and counter
    snd_addr_t   m_base, m_end, m_end_lat, m_cnt;
    logic        m_on, m_rep, m_play;
    logic        exp_req, exp_sint;   // Outputs due at the next falling edge
    snd_addr_t   exp_addr;

    string       test_name;
    int          checks, errors, tests, test_start_err;
    int unsigned seed;

    tb_clock_gen #(.PERIOD_NS(100.0)) u_clock_gen (.clk_o(clk32));

    snd_dma_top dut (
        .clk32      (clk32),
        .resb       (resb),
        .as_n_i     (as_n),
        .rw_i       (rw),
        .lds_n_i    (lds_n),
        .fc_i       (fc),
        .addr_i     (addr),
        .din_i      (din),
        .sreq_i     (sreq),
        .dout_o     (dout),
        .dtack_n_o  (dtack_n),
        .berr_n_o   (berr_n),
        .dma_req_o  (dma_req),
        .dma_addr_o (dma_addr),
        .sint_o     (sint)
    );

    task automatic compare(input string what, input logic [31:0] exp_v, input logic [31:0] act_v);
        checks++;
        if (exp_v !== act_v) begin
            errors++;
            $display("error %s %s expected %h actual %h", test_name, what, exp_v, act_v);
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s in test %s", why, test_name);
        $display("TEST FAILED");
        $finish;
    endtask

    task automatic start_test(input string name);
        test_name      = name;
        test_start_err = errors;
    endtask

    task automatic end_test();
        tests++;
        $display("test %s done with %0d errors", test_name, errors - test_start_err);
    endtask

    // Lane 0 is the high byte of the 24-bit byte address
    function automatic logic [7:0] lane_byte(input snd_addr_t a, input int lane);
        logic [23:0] byte_addr;
        byte_addr = {2'b00, a, 1'b0};
        return byte_addr[(2 - lane) * 8 +: 8];
    endfunction

    function automatic snd_addr_t lane_merge(input snd_addr_t a, input int lane,
                                             input logic [7:0] d);
        logic [23:0] byte_addr;
        byte_addr = {2'b00, a, 1'b0};
        byte_addr[(2 - lane) * 8 +: 8] = d;
        return byte_addr[21:1];   // Bits 23:22 and bit 0 are not stored
    endfunction

    function automatic logic [7:0] exp_read(input int word);
        if (word == 0) begin
            return {6'b000000, m_rep, m_on};
        end
        if (word < 4) begin
            return lane_byte(m_base, word - 1);
        end
        if (word < 7) begin
            return lane_byte(m_cnt, word - 4);
        end
        return lane_byte(m_end, word - 7);
    endfunction

    // Checks the outputs of the previous clock and drives the next request
    task automatic step(input logic req);
        @(negedge clk32);
        compare("dma_req", exp_req, dma_req);
        if (exp_req) begin
            compare("dma_addr", exp_addr, dma_addr);
        end
        compare("sint", exp_sint, sint);
        sreq     = req;
        exp_req  = req & m_play;
        exp_sint = 1'b0;
        if (exp_req) begin
            exp_addr = m_cnt;
            m_cnt    = m_cnt + 1'b1;
            if (m_cnt == m_end_lat) begin
                exp_sint = 1'b1;
                if (m_rep) begin
                    m_cnt     = m_base;
                    m_end_lat = m_end;   // New frame picks up the written end
                end else begin
                    m_play = 1'b0;
                    m_on   = 1'b0;
                end
            end
        end
    endtask

    task automatic drive_strobe(input int word, input logic rd_wr);
        logic [23:0] byte_addr;
        byte_addr = {`SND_DEV_PAGE, `SND_PAGE, 4'h0} + 24'(word * 2) + 24'd1;  // Odd byte
        addr  = byte_addr[23:1];
        fc    = 3'b101;   // Supervisor data
        rw    = rd_wr;
        as_n  = 1'b0;
        lds_n = 1'b0;
    endtask

    task automatic release_strobe();
        as_n  = 1'b1;
        lds_n = 1'b1;
        rw    = 1'b1;
    endtask

    task automatic bus_access(input int word, input logic wr, input logic [7:0] data,
                              output logic [7:0] rd);
        int n;
        step(1'b0);
        drive_strobe(word, ~wr);
        din = data;
        n = 0;
        while (dtack_n && n < WAIT_MAX) begin
            @(negedge clk32);
            n++;
        end
        if (dtack_n) begin
            abort_run("no DTACK on a sound register access");
        end
        rd = dout;
        release_strobe();
        n = 0;
        while (!dtack_n && n < WAIT_MAX) begin
            @(negedge clk32);
            n++;
        end
        if (!dtack_n) begin
            abort_run("DTACK stayed low after the strobe was released");
        end
    endtask

    task automatic reg_write(input int word, input logic [7:0] d);
        logic [7:0] rd;
        bus_access(word, 1'b1, d, rd);
        if (word == 0) begin
            m_on  = d[0];
            m_rep = d[1];
            if (d[0] && !m_play) begin
                m_play    = 1'b1;   // Frame starts from the current base
                m_cnt     = m_base;
                m_end_lat = m_end;
            end else if (!d[0]) begin
                m_play = 1'b0;
            end
        end else if (word < 4) begin
            m_base = lane_merge(m_base, word - 1, d);
        end else if (word >= 7) begin
            m_end = lane_merge(m_end, word - 7, d);
        end
    endtask

    task automatic reg_read(input int word);
        logic [7:0] rd;
        bus_access(word, 1'b0, 8'h00, rd);
        compare($sformatf("read word %0d", word), exp_read(word), rd);
    endtask

    task automatic write_addr(input int first_word, input snd_addr_t a);
        int l;
        for (l = 0; l < 3; l++) begin
            reg_write(first_word + l, lane_byte(a, l));
        end
    endtask

    task automatic bus_response();
        int   n;
        logic acked;
        step(1'b0);
        drive_strobe(0, 1'b1);
        n = 0;
        do begin
            @(negedge clk32);
            n++;
        end while (dtack_n && n < WAIT_MAX);
        compare("dtack delay", `SND_ACK_DELAY, n - 1);  // n = 1 follows the sampling edge
        release_strobe();
        n = 0;
        while (!dtack_n && n < WAIT_MAX) begin
            @(negedge clk32);
            n++;
        end
        if (!dtack_n) begin
            abort_run("DTACK stayed low after the strobe was released");
        end
        step(1'b0);
        drive_strobe(10, 1'b1);   // First word past the page
        n     = 0;
        acked = 1'b0;
        do begin
            @(negedge clk32);
            n++;
            acked = acked | ~dtack_n;
        end while (berr_n && n < WAIT_MAX);
        compare("berr delay", `SND_BERR_CYCLES, n);
        compare("dtack on unmapped", 0, acked);
        compare("dout on unmapped", 8'hFF, dout);
        release_strobe();
        n = 0;
        while (!berr_n && n < WAIT_MAX) begin
            @(negedge clk32);
            n++;
        end
        if (!berr_n) begin
            abort_run("bus error stayed low after the strobe was released");
        end
    endtask

    initial begin
        int        w;
        int        len;
        snd_addr_t base;
        seed = 32'hc7d3e1b5;
        void'($urandom(seed));
        resb  = 1'b0;
        as_n  = 1'b1;
        lds_n = 1'b1;
        rw    = 1'b1;
        fc    = 3'b000;
        addr  = '0;
        din   = 8'h00;
        sreq  = 1'b0;
        {m_base, m_end, m_end_lat, m_cnt, exp_addr} = '0;
        {m_on, m_rep, m_play, exp_req, exp_sint} = '0;
        {checks, errors, tests} = '0;
        repeat (8) @(negedge clk32);
        resb = 1'b1;

        start_test("reset");
        compare("dtack_n", 1, dtack_n);
        compare("berr_n", 1, berr_n);
        compare("dma_req", 0, dma_req);
        compare("sint", 0, sint);
        for (w = 0; w < 10; w++) begin
            reg_read(w);
        end
        end_test();

        start_test("reg_round_trip");
        for (w = 1; w < 10; w++) begin
            reg_write(w, 8'($urandom));   // Count words must be dropped
        end
        reg_write(0, 8'($urandom));
        for (w = 0; w < 10; w++) begin
            reg_read(w);
        end
        reg_write(0, 8'h00);
        end_test();

        start_test("bus_response");
        bus_response();
        end_test();

        start_test("one_shot");
        base = snd_addr_t'($urandom % 32'h4000);
        len  = 2 + $urandom % 7;
        write_addr(1, base);
        write_addr(7, snd_addr_t'(base + len));
        reg_write(0, 8'h01);
        for (w = 0; w < len; w++) begin
            step(1'b1);
            repeat ($urandom % 4) step(1'b0);
        end
        reg_read(0);
        step(1'b1);   // Sound is off now
        step(1'b0);
        step(1'b0);
        end_test();

        start_test("repeat");
        base = snd_addr_t'($urandom % 32'h4000);
        len  = 2 + $urandom % 5;
        write_addr(1, base);
        write_addr(7, snd_addr_t'(base + len));
        reg_write(0, 8'h03);
        for (w = 0; w < len - 1; w++) begin
            step(1'b1);
        end
        len = 2 + $urandom % 5;
        write_addr(7, snd_addr_t'(base + len));   // Applies from the next frame
        for (w = 0; w < 1 + 2 * len; w++) begin
            step(1'b1);
            if ($urandom % 2) begin
                step(1'b0);
            end
        end
        reg_write(0, 8'h00);
        end_test();

        start_test("count_bursts");
        base = snd_addr_t'($urandom % 32'h4000);
        len  = 16 + $urandom % 24;
        write_addr(1, base);
        write_addr(7, snd_addr_t'(base + len));
        reg_write(0, 8'h03);
        for (w = 0; w < 8; w++) begin
            repeat (1 + $urandom % 8) step(1'b1);
            reg_read(4);
            reg_read(5);
            reg_read(6);
        end
        reg_write(0, 8'h00);
        end_test();

        $display("tests %0d checks %0d errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verification/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

// Free running testbench clock
module tb_clock_gen #(
    parameter real PERIOD_NS = 100.0
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2.0) clk_o = ~clk_o;
        end
    end

endmodule

`default_nettype wire

/* logic/snd_dma_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "snd_dma_cfg.svh"

module snd_dma_top (
    input  logic                   clk32,
    input  logic                   resb,
    input  logic                   as_n_i,
    input  logic                   rw_i,
    input  logic                   lds_n_i,
    input  logic [2:0]             fc_i,
    input  logic [23:1]            addr_i,
    input  logic [7:0]             din_i,
    input  logic                   sreq_i,
    output logic [7:0]             dout_o,
    output logic                   dtack_n_o,
    output logic                   berr_n_o,
    output logic                   dma_req_o,
    output logic [`SND_ADDR_W:1]   dma_addr_o,
    output logic                   sint_o
);
    import snd_dma_pkg::*;

    snd_reg_e  reg_sel;
    logic      wr_stb;
    logic      snd_on;
    logic      snd_rep;
    snd_addr_t frame_base;
    snd_addr_t frame_end;
    snd_addr_t snd_cnt;
    logic      frame_start;
    logic      snd_stop;

    bus_decode u_bus_decode (
        .clk32     (clk32),
        .resb      (resb),
        .as_n_i    (as_n_i),
        .rw_i      (rw_i),
        .lds_n_i   (lds_n_i),
        .fc_i      (fc_i),
        .addr_i    (addr_i),
        .reg_sel_o (reg_sel),
        .wr_stb_o  (wr_stb),
        .dtack_n_o (dtack_n_o),
        .berr_n_o  (berr_n_o)
    );

    snd_regs u_snd_regs (
        .clk32         (clk32),
        .resb          (resb),
        .reg_sel_i     (reg_sel),
        .wr_stb_i      (wr_stb),
        .din_i         (din_i),
        .snd_cnt_i     (snd_cnt),
        .frame_start_i (frame_start),
        .snd_stop_i    (snd_stop),
        .dout_o        (dout_o),
        .snd_on_o      (snd_on),
        .snd_rep_o     (snd_rep),
        .frame_base_o  (frame_base),
        .frame_end_o   (frame_end)
    );

    snd_counter u_snd_counter (
        .clk32         (clk32),
        .resb          (resb),
        .sreq_i        (sreq_i),
        .snd_on_i      (snd_on),
        .snd_rep_i     (snd_rep),
        .frame_base_i  (frame_base),
        .frame_end_i   (frame_end),
        .snd_cnt_o     (snd_cnt),
        .frame_start_o (frame_start),
        .snd_stop_o    (snd_stop),
        .dma_req_o     (dma_req_o),
        .dma_addr_o    (dma_addr_o),
        .sint_o        (sint_o)
    );

endmodule

`default_nettype wire

/* logic/snd_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module snd_counter (
    input  logic                   clk32,
    input  logic                   resb,
    input  logic                   sreq_i,
    input  logic                   snd_on_i,
    input  logic                   snd_rep_i,
    input  snd_dma_pkg::snd_addr_t frame_base_i,
    input  snd_dma_pkg::snd_addr_t frame_end_i,
    output snd_dma_pkg::snd_addr_t snd_cnt_o,
    output logic                   frame_start_o,
    output logic                   snd_stop_o,
    output logic                   dma_req_o,
    output snd_dma_pkg::snd_addr_t dma_addr_o,
    output logic                   sint_o
);
    import snd_dma_pkg::*;

    snd_state_e state;
    snd_addr_t  cnt_inc;
    logic       start_now;
    logic       play_req;
    logic       hit_end;

    assign cnt_inc   = snd_cnt_o + 1'b1;
    assign start_now = (state == ST_IDLE) & snd_on_i;
    assign play_req  = (state == ST_PLAY) & snd_on_i & sreq_i;  // Idle requests ignored
    assign hit_end   = play_req & (cnt_inc == frame_end_i);

    // Both pulses act on the same edge as the counter update
    assign frame_start_o = start_now | (hit_end & snd_rep_i);
    assign snd_stop_o    = hit_end & ~snd_rep_i;

    always_ff @(posedge clk32 or negedge resb) begin
        if (!resb) begin
            state      <= ST_IDLE;
            snd_cnt_o  <= '0;
            dma_req_o  <= 1'b0;
            dma_addr_o <= '0;
            sint_o     <= 1'b0;
        end else begin
            dma_req_o <= play_req;
            sint_o    <= hit_end;   // One per frame end
            if (play_req) begin
                dma_addr_o <= snd_cnt_o;  // Address before increment
            end
            case (state)
                ST_IDLE: begin
                    if (start_now) begin
                        snd_cnt_o <= frame_base_i;
                        state     <= ST_PLAY;
                    end
                end
                ST_PLAY: begin
                    if (!snd_on_i) begin
                        state <= ST_IDLE;  // CPU switched sound off
                    end else if (hit_end) begin
                        if (snd_rep_i) begin
                            snd_cnt_o <= frame_base_i;
                        end else begin
                            snd_cnt_o <= cnt_inc;
                            state     <= ST_IDLE;
                        end
                    end else if (play_req) begin
                        snd_cnt_o <= cnt_inc;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* logic/snd_regs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "snd_dma_cfg.svh"

module snd_regs (
    input  logic                   clk32,
    input  logic                   resb,
    input  snd_dma_pkg::snd_reg_e  reg_sel_i,
    input  logic                   wr_stb_i,
    input  logic [7:0]             din_i,
    input  snd_dma_pkg::snd_addr_t snd_cnt_i,
    input  logic                   frame_start_i,
    input  logic                   snd_stop_i,
    output logic [7:0]             dout_o,
    output logic                   snd_on_o,
    output logic                   snd_rep_o,
    output snd_dma_pkg::snd_addr_t frame_base_o,
    output snd_dma_pkg::snd_addr_t frame_end_o
);
    import snd_dma_pkg::*;

    localparam logic [1:0] LANE_L = 2'd0;
    localparam logic [1:0] LANE_M = 2'd1;
    localparam logic [1:0] LANE_H = 2'd2;

    logic [1:0] lane;
    snd_addr_t  end_wr;   // End as written by the CPU

    // Merge one data byte into its lane of a word address
    function automatic snd_addr_t put_lane(snd_addr_t cur, logic [1:0] ln, logic [7:0] d);
        snd_addr_t nxt;
        nxt = cur;
        case (ln)
            LANE_H:  nxt[21:16] = d[5:0];
            LANE_M:  nxt[15:8]  = d;
            default: nxt[7:1]   = d[7:1];  // Word aligned, bit 0 dropped
        endcase
        return nxt;
    endfunction

    function automatic logic [7:0] get_lane(snd_addr_t a, logic [1:0] ln);
        logic [7:0] b;
        case (ln)
            LANE_H:  b = {2'b00, a[21:16]};
            LANE_M:  b = a[15:8];
            default: b = {a[7:1], 1'b0};
        endcase
        return b;
    endfunction

    always_comb begin
        case (reg_sel_i)
            REG_BASE_H, REG_CNT_H, REG_END_H: lane = LANE_H;
            REG_BASE_M, REG_CNT_M, REG_END_M: lane = LANE_M;
            default:                          lane = LANE_L;
        endcase
    end

    always_ff @(posedge clk32 or negedge resb) begin
        if (!resb) begin
            snd_on_o     <= 1'b0;
            snd_rep_o    <= 1'b0;
            frame_base_o <= '0;
            end_wr       <= '0;
            frame_end_o  <= '0;
        end else begin
            if (snd_stop_i) begin
                snd_on_o <= 1'b0;
            end
            // New end only takes effect at a frame boundary
            if (frame_start_i) begin
                frame_end_o <= end_wr;
            end
            if (wr_stb_i) begin
                case (reg_sel_i)
                    REG_CTRL: begin
                        snd_on_o  <= din_i[`SND_CTRL_ON];
                        snd_rep_o <= din_i[`SND_CTRL_REP];
                    end
                    REG_BASE_H, REG_BASE_M, REG_BASE_L: begin
                        frame_base_o <= put_lane(frame_base_o, lane, din_i);
                    end
                    REG_END_H, REG_END_M, REG_END_L: begin
                        end_wr <= put_lane(end_wr, lane, din_i);
                    end
                    default: ;  // Count and unmapped writes dropped
                endcase
            end
        end
    end

    // Read back
    always_comb begin
        dout_o = 8'hFF;
        case (reg_sel_i)
            REG_CTRL: begin
                dout_o = 8'h00;
                dout_o[`SND_CTRL_ON]  = snd_on_o;
                dout_o[`SND_CTRL_REP] = snd_rep_o;
            end
            REG_BASE_H, REG_BASE_M, REG_BASE_L: dout_o = get_lane(frame_base_o, lane);
            REG_CNT_H, REG_CNT_M, REG_CNT_L:    dout_o = get_lane(snd_cnt_i, lane);
            REG_END_H, REG_END_M, REG_END_L:    dout_o = get_lane(end_wr, lane);
            default:                            dout_o = 8'hFF;
        endcase
    end

endmodule

`default_nettype wire

/* logic/bus_decode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "snd_dma_cfg.svh"

module bus_decode (
    input  logic                  clk32,
    input  logic                  resb,
    input  logic                  as_n_i,
    input  logic                  rw_i,
    input  logic                  lds_n_i,
    input  logic [2:0]            fc_i,
    input  logic [23:1]           addr_i,
    output snd_dma_pkg::snd_reg_e reg_sel_o,
    output logic                  wr_stb_o,
    output logic                  dtack_n_o,
    output logic                  berr_n_o
);
    import snd_dma_pkg::*;

    localparam logic [11:0]            PAGE     = `SND_PAGE;
    localparam logic [`SND_BERR_W-1:0] BERR_MAX = `SND_BERR_CYCLES;

    logic                     ias;
    logic                     ilds;
    logic                     idev;
    logic                     page_hit;
    logic                     sel;
    logic [`SND_ACK_DELAY:0]  ack_sr;     // Bit 0 is the sampled select
    logic [`SND_BERR_W-1:0]   berr_cnt;

    assign ias  = ~as_n_i;
    assign ilds = ~lds_n_i;

    // Supervisor data or program space, device page only
    assign idev = fc_i[2] & (fc_i[0] ^ fc_i[1]) & (addr_i[23:16] == `SND_DEV_PAGE);

    // FF8900-FF8913, A[4] splits the page in two halves
    assign page_hit = (addr_i[15:5] == PAGE[11:1]) & (addr_i[4:1] <= `SND_WORD_LAST);

    assign sel = idev & page_hit & ias & ilds;

    always_comb begin
        if (sel) begin
            reg_sel_o = snd_reg_e'(addr_i[4:1]);
        end else begin
            reg_sel_o = REG_NONE;
        end
    end

    // First edge of a selected write cycle
    assign wr_stb_o = sel & ~rw_i & ~ack_sr[0];

    // DTACK delay line, flushed as soon as the strobe goes away
    always_ff @(posedge clk32 or negedge resb) begin
        if (!resb) begin
            ack_sr <= '0;
        end else if (sel) begin
            ack_sr <= {ack_sr[`SND_ACK_DELAY-1:0], 1'b1};
        end else begin
            ack_sr <= '0;
        end
    end

    assign dtack_n_o = ~ack_sr[`SND_ACK_DELAY];

    // Bus error watchdog
    // Only runs while AS is held and nothing here answers
    always_ff @(posedge clk32 or negedge resb) begin
        if (!resb) begin
            berr_cnt <= '0;
        end else if (!ias || sel) begin
            berr_cnt <= '0;
        end else if (berr_cnt != BERR_MAX) begin
            berr_cnt <= berr_cnt + 1'b1;  // Saturates at BERR_MAX
        end
    end

    assign berr_n_o = (berr_cnt != BERR_MAX);

endmodule

`default_nettype wire

/* logic/snd_dma_pkg.sv */
`default_nettype none

`include "snd_dma_cfg.svh"

package snd_dma_pkg;

    // Word address of a sound sample pair
    typedef logic [`SND_ADDR_W:1] snd_addr_t;

    // Register being accessed, value equals word index A[4:1]
    typedef enum logic [3:0] {
        REG_CTRL   = 4'd0,
        REG_BASE_H = 4'd1,
        REG_BASE_M = 4'd2,
        REG_BASE_L = 4'd3,
        REG_CNT_H  = 4'd4,   // Count is read only
        REG_CNT_M  = 4'd5,
        REG_CNT_L  = 4'd6,
        REG_END_H  = 4'd7,
        REG_END_M  = 4'd8,
        REG_END_L  = 4'd9,
        REG_NONE   = 4'hF
    } snd_reg_e;

    typedef enum logic {ST_IDLE, ST_PLAY} snd_state_e;

endpackage

`default_nettype wire

/* logic/snd_dma_cfg.svh */
`ifndef SND_DMA_CFG_SVH
`define SND_DMA_CFG_SVH

// DMA sound address generator constants

// Sound DMA word address, bits 21:1
`define SND_ADDR_W       21

// Register page decode
// Device space is A[23:16] = FF
`define SND_DEV_PAGE     8'hFF

// Upper address bits A[15:4] of the page FF8900-FF8913
`define SND_PAGE         12'h890

// Last valid word index on the page (FF8912)
`define SND_WORD_LAST    4'd9

// Control byte bit positions
`define SND_CTRL_ON      0   // Sound DMA enable
`define SND_CTRL_REP     1   // Repeat frame

// Bus timing
// Cycles from the sampled strobe to DTACK
`define SND_ACK_DELAY    2

// Strobe cycles without any selection before BERR
`define SND_BERR_CYCLES  64

// Watchdog counter must hold SND_BERR_CYCLES
`define SND_BERR_W       7

`endif
